// File: hw/tlb_field_pkg.sv
package tlb_field_pkg;

    // virtual double-page number, va[31:13]
    typedef logic [18:0] vppn_t;
    // page number of a request, va[31:12]
    typedef logic [19:0] va_page_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    // 4 KB halves, anything else behaves as 2 MB
    localparam ps_t PS_4K = 6'd12;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_half_t;

    typedef struct packed {
        vppn_t     vppn;
        asid_t     asid;
        logic      g;
        ps_t       ps;
        logic      e;
        tlb_half_t half0;
        tlb_half_t half1;
    } tlb_entry_t;

    // address compare shared by lookup and invalidate
    function automatic logic va_match(ps_t ps, vppn_t vppn, va_page_t va_page);
        return (ps == PS_4K) ? (vppn == va_page[19:1])
                             : (vppn[18:9] == va_page[19:10]);
    endfunction

endpackage

// File: hw/tlb_port_pkg.sv
package tlb_port_pkg;

    import tlb_field_pkg::*;

    // enough for up to 64 entries
    localparam int TLB_INDEX_W = 6;

    typedef struct packed {
        va_page_t va_page;
        asid_t    asid;
    } tlb_s_req_t;

    typedef struct packed {
        logic                   found;
        logic [TLB_INDEX_W-1:0] index;
        ps_t                    ps;
        tlb_half_t              half;
    } tlb_s_resp_t;

    typedef struct packed {
        logic                   we;
        logic [TLB_INDEX_W-1:0] index;
        tlb_entry_t             entry;
    } tlb_w_req_t;

    // op codes 7 to 31 leave every entry alone
    typedef enum logic [4:0] {
        INV_ALL0              = 5'd0,
        INV_ALL1              = 5'd1,
        INV_GLOBAL            = 5'd2,
        INV_NONGLOBAL         = 5'd3,
        INV_ASID              = 5'd4,
        INV_ASID_VA           = 5'd5,
        INV_GLOBAL_OR_ASID_VA = 5'd6
    } tlb_inv_op_e;

    typedef struct packed {
        logic        en;
        tlb_inv_op_e op;
        asid_t       asid;
        va_page_t    va_page;
    } tlb_inv_req_t;

endpackage

// File: hw/tlb_inv_decode.sv
module tlb_inv_decode #(
    parameter int TLB_ENTRY_NUM = 16
) (
    input  tlb_field_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] entries_i,
    input  tlb_port_pkg::tlb_inv_req_t                    inv_req_i,
    output logic [TLB_ENTRY_NUM-1:0]                      clear_mask_o
);

    import tlb_field_pkg::*;
    import tlb_port_pkg::*;

    for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_entry
        logic asid_hit;
        logic va_hit;
        logic rule_hit;

        assign asid_hit = (entries_i[i].asid == inv_req_i.asid);
        assign va_hit   = va_match(entries_i[i].ps, entries_i[i].vppn, inv_req_i.va_page);

        always_comb begin
            case (inv_req_i.op)
                INV_ALL0, INV_ALL1: begin
                    rule_hit = 1'b1;
                end
                INV_GLOBAL: begin
                    rule_hit = entries_i[i].g;
                end
                INV_NONGLOBAL: begin
                    rule_hit = !entries_i[i].g;
                end
                INV_ASID: begin
                    rule_hit = !entries_i[i].g && asid_hit;
                end
                INV_ASID_VA: begin
                    rule_hit = !entries_i[i].g && asid_hit && va_hit;
                end
                // global entries match on address alone
                INV_GLOBAL_OR_ASID_VA: begin
                    rule_hit = (entries_i[i].g || asid_hit) && va_hit;
                end
                default: begin
                    rule_hit = 1'b0;
                end
            endcase
        end

        assign clear_mask_o[i] = inv_req_i.en && rule_hit;
    end

endmodule

// File: hw/tlb_entry_array.sv
module tlb_entry_array #(
    parameter int TLB_ENTRY_NUM = 16
) (
    input  logic                                          clk,
    input  logic                                          rst_i,
    input  tlb_port_pkg::tlb_w_req_t                      w_req_i,
    input  logic [TLB_ENTRY_NUM-1:0]                      clear_mask_i,
    input  logic [$clog2(TLB_ENTRY_NUM)-1:0]              r_index_i,
    output tlb_field_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] entries_o,
    output tlb_field_pkg::tlb_entry_t                     r_entry_o
);

    import tlb_field_pkg::*;
    import tlb_port_pkg::*;

    tlb_entry_t [TLB_ENTRY_NUM-1:0] entry_q;
    logic [TLB_ENTRY_NUM-1:0]       write_sel;

    // full index compare, out of range writes are dropped
    for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_sel
        assign write_sel[i] = w_req_i.we && (w_req_i.index == TLB_INDEX_W'(i));
    end

    // only the exist bits see reset
    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (rst_i) begin
                entry_q[i].e <= 1'b0;
            end else if (write_sel[i]) begin
                // write beats a clear of the same index
                entry_q[i] <= w_req_i.entry;
            end else if (clear_mask_i[i]) begin
                entry_q[i].e <= 1'b0;
            end
        end
    end

    assign entries_o = entry_q;

    // indexed read
    assign r_entry_o = entry_q[r_index_i];

endmodule

// File: hw/tlb_lookup.sv
module tlb_lookup #(
    parameter int TLB_ENTRY_NUM = 16
) (
    input  tlb_field_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] entries_i,
    input  tlb_port_pkg::tlb_s_req_t                      req_i,
    output tlb_port_pkg::tlb_s_resp_t                     resp_o
);

    import tlb_field_pkg::*;
    import tlb_port_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

    logic [TLB_ENTRY_NUM-1:0] hit;
    logic [IDX_W-1:0]         hit_index;
    logic                     found;
    tlb_entry_t               hit_entry;
    logic                     odd_sel;

    for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_match
        assign hit[i] = entries_i[i].e
                     && (entries_i[i].g || (entries_i[i].asid == req_i.asid))
                     && va_match(entries_i[i].ps, entries_i[i].vppn, req_i.va_page);
    end

    // lowest index wins, so scan from the top down
    always_comb begin
        hit_index = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_index = IDX_W'(i);
            end
        end
    end

    assign found     = |hit;
    assign hit_entry = entries_i[hit_index];

    // even/odd half select
    assign odd_sel = (hit_entry.ps == PS_4K) ? req_i.va_page[0] : req_i.va_page[9];

    always_comb begin
        resp_o = '0;
        if (found) begin
            resp_o.found = 1'b1;
            resp_o.index = TLB_INDEX_W'(hit_index);
            resp_o.ps    = hit_entry.ps;
            resp_o.half  = odd_sel ? hit_entry.half1 : hit_entry.half0;
        end
    end

endmodule

// File: hw/tlb.sv
module tlb #(
    parameter int TLB_ENTRY_NUM = 16,
    parameter int TLB_PORT      = 2
) (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  tlb_port_pkg::tlb_s_req_t                   s_instr_req_i,
    output tlb_port_pkg::tlb_s_resp_t                  s_instr_resp_o,
    input  tlb_port_pkg::tlb_s_req_t  [TLB_PORT-1:0]   s_data_req_i,
    output tlb_port_pkg::tlb_s_resp_t [TLB_PORT-1:0]   s_data_resp_o,
    input  tlb_port_pkg::tlb_w_req_t                   w_req_i,
    input  logic [$clog2(TLB_ENTRY_NUM)-1:0]           r_index_i,
    output tlb_field_pkg::tlb_entry_t                  r_entry_o,
    input  tlb_port_pkg::tlb_inv_req_t                 inv_req_i
);

    import tlb_field_pkg::*;

    tlb_entry_t [TLB_ENTRY_NUM-1:0] entries;
    logic [TLB_ENTRY_NUM-1:0]       clear_mask;

    // invalidate mask from the current entry state
    tlb_inv_decode #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_inv_decode (
        .entries_i   (entries),
        .inv_req_i   (inv_req_i),
        .clear_mask_o(clear_mask)
    );

    tlb_entry_array #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_entry_array (
        .clk         (clk),
        .rst_i       (rst_i),
        .w_req_i     (w_req_i),
        .clear_mask_i(clear_mask),
        .r_index_i   (r_index_i),
        .entries_o   (entries),
        .r_entry_o   (r_entry_o)
    );

    tlb_lookup #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_lookup_instr (
        .entries_i(entries),
        .req_i    (s_instr_req_i),
        .resp_o   (s_instr_resp_o)
    );

    for (genvar p = 0; p < TLB_PORT; p++) begin : g_data
        tlb_lookup #(
            .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
        ) u_lookup_data (
            .entries_i(entries),
            .req_i    (s_data_req_i[p]),
            .resp_o   (s_data_resp_o[p])
        );
    end

endmodule

// File: sim/tlb_tb.sv
module tlb_tb;

    import tlb_field_pkg::*;
    import tlb_port_pkg::*;

    localparam int NUM = 16;
    localparam int PORTS = 2;
    // the stimulus runs for about 540 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    typedef tlb_entry_t [NUM-1:0] entry_vec_t;

    logic                      clk;
    logic                      rst_i;
    tlb_s_req_t                instr_req;
    tlb_s_resp_t               instr_resp;
    tlb_s_req_t  [PORTS-1:0]   data_req;
    tlb_s_resp_t [PORTS-1:0]   data_resp;
    tlb_w_req_t                w_req;
    logic [$clog2(NUM)-1:0]    r_index;
    tlb_entry_t                r_entry;
    tlb_inv_req_t              inv_req;

    entry_vec_t                model;
    logic [NUM-1:0]            written;
    tlb_s_resp_t               exp_instr;
    tlb_s_resp_t [PORTS-1:0]   exp_data;
    logic                      read_ok;
    int                        seed = 21;
    int                        errors = 0;
    int                        checks = 0;
    int                        cycles = 0;
    string                     test_name = "reset";

    tlb #(
        .TLB_ENTRY_NUM(NUM),
        .TLB_PORT     (PORTS)
    ) dut0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .s_instr_req_i (instr_req),
        .s_instr_resp_o(instr_resp),
        .s_data_req_i  (data_req),
        .s_data_resp_o (data_resp),
        .w_req_i       (w_req),
        .r_index_i     (r_index),
        .r_entry_o     (r_entry),
        .inv_req_i     (inv_req)
    );

    always #50 clk = ~clk;

    function automatic logic page_match(ps_t ps, vppn_t vppn, va_page_t va);
        if (ps == 6'd12) begin
            return vppn == va[19:1];
        end
        return vppn[18:9] == va[19:10];
    endfunction

    function automatic logic inv_hits(tlb_entry_t ent, tlb_inv_req_t req);
        logic same_asid;
        logic same_page;
        same_asid = (ent.asid == req.asid);
        same_page = page_match(ent.ps, ent.vppn, req.va_page);
        case (int'(req.op))
            0, 1: return 1'b1;
            2: return ent.g;
            3: return !ent.g;
            4: return !ent.g && same_asid;
            5: return !ent.g && same_asid && same_page;
            6: return (ent.g || same_asid) && same_page;
            default: return 1'b0;
        endcase
    endfunction

    function automatic tlb_s_resp_t search_model(entry_vec_t ents, tlb_s_req_t req);
        tlb_s_resp_t resp;
        logic        odd;
        resp = '0;
        for (int i = 0; i < NUM; i++) begin
            if (!resp.found && ents[i].e && (ents[i].g || ents[i].asid == req.asid)
                    && page_match(ents[i].ps, ents[i].vppn, req.va_page)) begin
                odd = (ents[i].ps == 6'd12) ? req.va_page[0] : req.va_page[9];
                resp.found = 1'b1;
                resp.index = TLB_INDEX_W'(i);
                resp.ps    = ents[i].ps;
                resp.half  = odd ? ents[i].half1 : ents[i].half0;
            end
        end
        return resp;
    endfunction

    // reference state follows the DUT on each edge
    always @(posedge clk) begin
        for (int i = 0; i < NUM; i++) begin
            if (rst_i) begin
                model[i].e <= 1'b0;
                written[i] <= 1'b0;
            end else if (w_req.we && int'(w_req.index) == i) begin
                model[i]   <= w_req.entry;
                written[i] <= 1'b1;
            end else if (inv_req.en && inv_hits(model[i], inv_req)) begin
                model[i].e <= 1'b0;
            end
        end
    end

    always_comb begin
        exp_instr = search_model(model, instr_req);
        for (int p = 0; p < PORTS; p++) begin
            exp_data[p] = search_model(model, data_req[p]);
        end
        read_ok = written[r_index] ? (r_entry == model[r_index]) : !r_entry.e;
    end

    assert property (@(posedge clk) disable iff (rst_i) instr_resp == exp_instr)
        else begin
            errors++;
            $display("[FAIL] %s instr search: expected %h actual %h",
                     test_name, $sampled(exp_instr), $sampled(instr_resp));
        end

    for (genvar p = 0; p < PORTS; p++) begin : g_data_chk
        assert property (@(posedge clk) disable iff (rst_i) data_resp[p] == exp_data[p])
            else begin
                errors++;
                $display("[FAIL] %s data search %0d: expected %h actual %h",
                         test_name, p, $sampled(exp_data[p]), $sampled(data_resp[p]));
            end
    end

    assert property (@(posedge clk) disable iff (rst_i) read_ok)
        else begin
            errors++;
            $display("[FAIL] %s read %0d: expected %h actual %h", test_name,
                     $sampled(r_index), $sampled(model[r_index]), $sampled(r_entry));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst_i) begin
            checks <= checks + 2 + PORTS;
        end
        if (cycles == TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, errors: %0d, checks: %0d",
                     TIMEOUT_CYCLES, errors, checks);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic make_entry(output tlb_entry_t ent);
        logic [31:0] r;
        r = $random(seed);
        // few vppn high bits so that 2 MB and 4 KB pages overlap
        ent.vppn  = {8'd0, r[1:0], r[10:2]};
        ent.asid  = {8'd0, r[12:11]};
        ent.g     = r[13] & r[14];
        ent.ps    = r[15] ? 6'd12 : (r[16] ? 6'd21 : 6'd14);
        ent.e     = r[17] | r[18];
        r = $random(seed);
        ent.half0 = r[25:0];
        r = $random(seed);
        ent.half1 = r[25:0];
    endtask

    task automatic make_req(output tlb_s_req_t req);
        logic [31:0] r;
        tlb_entry_t  ent;
        r = $random(seed);
        if (r[0]) begin
            ent = model[r[4:1]];
            req.va_page = (ent.ps == 6'd12) ? {ent.vppn, r[5]} : {ent.vppn[18:9], r[15:6]};
            req.asid    = r[16] ? ent.asid : {8'd0, r[18:17]};
        end else begin
            req.va_page = {8'd0, r[2:1], r[19:10]};
            req.asid    = {8'd0, r[21:20]};
        end
    endtask

    task automatic tick();
        tlb_s_req_t req;
        make_req(req);
        instr_req = req;
        for (int p = 0; p < PORTS; p++) begin
            make_req(req);
            data_req[p] = req;
        end
        step();
    endtask

    task automatic fill_random();
        tlb_entry_t ent;
        for (int i = 0; i < NUM; i++) begin
            make_entry(ent);
            w_req.we    = 1'b1;
            w_req.index = TLB_INDEX_W'(i);
            w_req.entry = ent;
            tick();
        end
        w_req.we = 1'b0;
    endtask

    task automatic read_all();
        for (int i = 0; i < NUM; i++) begin
            r_index = 4'(i);
            tick();
        end
    endtask

    task automatic issue_inv(input int op);
        logic [31:0] r;
        tlb_entry_t  ent;
        r = $random(seed);
        ent = model[r[3:0]];
        inv_req.en      = 1'b1;
        inv_req.op      = tlb_inv_op_e'(5'(op));
        inv_req.asid    = r[4] ? ent.asid : {8'd0, r[6:5]};
        inv_req.va_page = (ent.ps == 6'd12) ? {ent.vppn, r[7]} : {ent.vppn[18:9], r[17:8]};
    endtask

    initial begin
        tlb_entry_t ent;
        clk       = 1'b0;
        rst_i     = 1'b1;
        instr_req = '0;
        data_req  = '0;
        w_req     = '0;
        r_index   = '0;
        inv_req   = '0;
        repeat (16) step();
        rst_i = 1'b0;

        // a second reset must drop everything written before it
        test_name = "fill before reset";
        fill_random();
        rst_i = 1'b1;
        repeat (16) step();
        rst_i = 1'b0;

        test_name = "empty search";
        read_all();
        repeat (20) tick();

        test_name = "fill and read";
        fill_random();
        read_all();

        test_name = "search";
        repeat (60) tick();

        for (int op = 0; op < 8; op++) begin
            test_name = $sformatf("invalidate op %0d", op);
            fill_random();
            issue_inv(op);
            tick();
            inv_req.en = 1'b0;
            read_all();
            repeat (8) tick();
        end

        // write and clear-all on the same edge
        test_name = "write with invalidate";
        fill_random();
        make_entry(ent);
        ent.e       = 1'b1;
        w_req.we    = 1'b1;
        w_req.index = TLB_INDEX_W'(5);
        w_req.entry = ent;
        issue_inv(0);
        tick();
        w_req.we   = 1'b0;
        inv_req.en = 1'b0;
        read_all();
        repeat (4) tick();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/tlb_field_pkg.sv
hw/tlb_port_pkg.sv
hw/tlb_inv_decode.sv
hw/tlb_entry_array.sv
hw/tlb_lookup.sv
hw/tlb.sv
sim/tlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tlb_tb -o tlb_sim \
    && ./obj_dir/tlb_sim | tee /dev/stderr | grep -F "TESTS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
